// File: source/audio_pkg.sv
package audio_pkg;

    // Duty cycle, PWM counter and sample width
    localparam int DUTY_W = 12;

    localparam int N_BUTTONS = 4;
    localparam int N_LEDS = 6;

    // APB register map, byte addresses
    typedef enum logic [7:0] {
        REG_CTRL    = 8'h00,
        REG_DUTY    = 8'h04,
        REG_FIFO    = 8'h08,
        REG_STATUS  = 8'h0C,
        REG_BUTTONS = 8'h10,
        REG_LEDS    = 8'h14
    } reg_addr_e;

    // Where the DAC takes its next duty cycle from
    typedef enum logic {
        SRC_DIRECT = 1'b0,
        SRC_FIFO   = 1'b1
    } dac_source_e;

endpackage

// File: source/button_parser.sv
`timescale 1ns/1ps

module button_parser import audio_pkg::*; #(
    parameter int SAMPLE_COUNT_MAX = 4,
    parameter int PULSE_COUNT_MAX = 3
) (
    input  logic                 cpu_clk_g,
    input  logic                 rst_n,
    input  logic [N_BUTTONS-1:0] buttons,
    output logic [N_BUTTONS-1:0] press
);

    localparam int SW = $clog2(SAMPLE_COUNT_MAX + 1);
    localparam int PW = $clog2(PULSE_COUNT_MAX + 1);
    localparam logic [SW-1:0] SAMPLE_LAST = SW'(SAMPLE_COUNT_MAX - 1);
    localparam logic [PW-1:0] PULSE_LAST = PW'(PULSE_COUNT_MAX - 1);
    localparam logic [PW-1:0] PULSE_MAX = PW'(PULSE_COUNT_MAX);

    logic [N_BUTTONS-1:0] sync_meta;
    logic [N_BUTTONS-1:0] sync_q;
    logic [SW-1:0]        sample_cnt;
    logic                 sample_tick;
    logic [PW-1:0]        high_cnt [N_BUTTONS];

    // Two-flop synchronizer on the raw button pins
    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= buttons;
            sync_q    <= sync_meta;
        end
    end

    // One sample tick every SAMPLE_COUNT_MAX cycles, shared by all buttons
    assign sample_tick = (sample_cnt == SAMPLE_LAST);

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n || sample_tick) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            press <= '0;
            for (int i = 0; i < N_BUTTONS; i++) begin
                high_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_BUTTONS; i++) begin
                // Fires only on the sample that brings the count up to the limit
                press[i] <= sample_tick && sync_q[i] && (high_cnt[i] == PULSE_LAST);
                if (sample_tick) begin
                    if (!sync_q[i]) begin
                        high_cnt[i] <= '0;
                    end else if (high_cnt[i] != PULSE_MAX) begin
                        high_cnt[i] <= high_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: source/audio_regs.sv
`timescale 1ns/1ps

module audio_regs import audio_pkg::*; (
    input  logic                 cpu_clk_g,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pslverr,
    input  logic [N_BUTTONS-1:0] press,
    output logic [N_LEDS-1:0]    leds,
    output dac_source_e          dac_source,
    output logic [DUTY_W-1:0]    duty,
    output logic                 req,
    input  logic                 ack,
    output logic                 wr_en,
    output logic [DUTY_W-1:0]    wr_data,
    input  logic                 full,
    input  logic                 empty
);

    logic                 access;
    logic                 addr_err;
    logic                 wr_ok;
    logic [N_BUTTONS-1:0] sticky;
    logic [N_BUTTONS-1:0] sticky_clr;

    assign access = psel && penable;

    always_comb begin
        case (paddr)
            REG_CTRL, REG_DUTY, REG_BUTTONS, REG_LEDS: addr_err = 1'b0;
            // Push only, and only while there is room
            REG_FIFO:   addr_err = !pwrite || full;
            REG_STATUS: addr_err = pwrite;
            default:    addr_err = 1'b1;
        endcase
    end

    assign pslverr = access && addr_err;
    assign wr_ok   = access && pwrite && !addr_err;

    assign wr_en   = wr_ok && (paddr == REG_FIFO);
    assign wr_data = pwdata[DUTY_W-1:0];

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_CTRL:    prdata = {31'b0, dac_source};
                REG_DUTY:    prdata = {{(32 - DUTY_W){1'b0}}, duty};
                REG_STATUS:  prdata = {29'b0, req, empty, full};
                REG_BUTTONS: prdata = {{(32 - N_BUTTONS){1'b0}}, sticky};
                REG_LEDS:    prdata = {{(32 - N_LEDS){1'b0}}, leds};
                default:     prdata = '0;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            dac_source <= SRC_DIRECT;
            leds       <= '0;
        end else if (wr_ok) begin
            if (paddr == REG_CTRL) begin
                dac_source <= dac_source_e'(pwdata[0]);
            end
            if (paddr == REG_LEDS) begin
                leds <= pwdata[N_LEDS-1:0];
            end
        end
    end

    // Direct duty handshake, a fresh write restarts the wait with the new value
    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            duty <= '0;
            req  <= 1'b0;
        end else if (wr_ok && (paddr == REG_DUTY)) begin
            duty <= pwdata[DUTY_W-1:0];
            req  <= 1'b1;
        end else if (ack) begin
            req <= 1'b0;
        end
    end

    // Write-1-to-clear, a press in the same cycle wins
    assign sticky_clr = (wr_ok && (paddr == REG_BUTTONS)) ? pwdata[N_BUTTONS-1:0] : '0;

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            sticky <= '0;
        end else begin
            sticky <= (sticky & ~sticky_clr) | press;
        end
    end

endmodule

// File: source/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import audio_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              cpu_clk_g,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [DUTY_W-1:0] wr_data,
    input  logic              rd_en,
    output logic [DUTY_W-1:0] rd_data,
    output logic              full,
    output logic              empty
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam logic [AW-1:0] PTR_LAST = AW'(FIFO_DEPTH - 1);
    localparam logic [CW-1:0] COUNT_FULL = CW'(FIFO_DEPTH);

    logic [DUTY_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              do_wr;
    logic              do_rd;

    assign full  = (count == COUNT_FULL);
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head entry straight out, no read latency
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge cpu_clk_g) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: source/pwm_dac.sv
`timescale 1ns/1ps

module pwm_dac import audio_pkg::*; (
    input  logic              cpu_clk_g,
    input  logic              rst_n,
    input  dac_source_e       dac_source,
    input  logic [DUTY_W-1:0] duty,
    input  logic              req,
    output logic              ack,
    output logic              rd_en,
    input  logic [DUTY_W-1:0] rd_data,
    input  logic              empty,
    output logic              pwm
);

    logic [DUTY_W-1:0] period_cnt;
    logic [DUTY_W-1:0] active_duty;
    logic              boundary;
    logic              load_direct;

    // Last cycle of the period, the new duty is in force from count 0
    assign boundary = (period_cnt == '1);

    assign load_direct = boundary && (dac_source == SRC_DIRECT) && req;

    // Pop at the boundary edge, together with the duty load
    assign rd_en = boundary && (dac_source == SRC_FIFO) && !empty;

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            active_duty <= '0;
            ack         <= 1'b0;
        end else begin
            ack <= load_direct;
            if (load_direct) begin
                active_duty <= duty;
            end else if (rd_en) begin
                active_duty <= rd_data;
            end
        end
    end

    // An empty FIFO simply leaves the previous duty running
    always_ff @(posedge cpu_clk_g) begin
        if (!rst_n) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (period_cnt < active_duty);
        end
    end

endmodule

// File: source/audio_top.sv
`timescale 1ns/1ps

module audio_top import audio_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int SAMPLE_COUNT_MAX = 45_000,
    parameter int PULSE_COUNT_MAX = 200
) (
    input  logic                 cpu_clk_g,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pslverr,
    input  logic [N_BUTTONS-1:0] buttons,
    output logic [N_LEDS-1:0]    leds,
    output logic                 pwm
);

    logic [N_BUTTONS-1:0] press;
    dac_source_e          dac_source;
    logic [DUTY_W-1:0]    duty;
    logic                 req;
    logic                 ack;
    logic                 wr_en;
    logic [DUTY_W-1:0]    wr_data;
    logic                 rd_en;
    logic [DUTY_W-1:0]    rd_data;
    logic                 full;
    logic                 empty;

    button_parser #(
        .SAMPLE_COUNT_MAX(SAMPLE_COUNT_MAX),
        .PULSE_COUNT_MAX (PULSE_COUNT_MAX)
    ) u_button_parser (
        .cpu_clk_g(cpu_clk_g),
        .rst_n    (rst_n),
        .buttons  (buttons),
        .press    (press)
    );

    audio_regs u_audio_regs (
        .cpu_clk_g (cpu_clk_g),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .press     (press),
        .leds      (leds),
        .dac_source(dac_source),
        .duty      (duty),
        .req       (req),
        .ack       (ack),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .full      (full),
        .empty     (empty)
    );

    sample_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_sample_fifo (
        .cpu_clk_g(cpu_clk_g),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .full     (full),
        .empty    (empty)
    );

    pwm_dac u_pwm_dac (
        .cpu_clk_g (cpu_clk_g),
        .rst_n     (rst_n),
        .dac_source(dac_source),
        .duty      (duty),
        .req       (req),
        .ack       (ack),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .empty     (empty),
        .pwm       (pwm)
    );

endmodule

// File: test/tb_audio_top.sv
`timescale 1ns/1ps

module tb_audio_top import audio_pkg::*; ();

    localparam int PERIOD = 1 << DUTY_W;
    // Roughly 18 PWM periods of tests plus margin
    localparam int TIMEOUT_CYCLES = 80_000;

    logic                 cpu_clk_g;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [7:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pslverr;
    logic [N_BUTTONS-1:0] buttons;
    logic [N_LEDS-1:0]    leds;
    logic                 pwm;

    int                   cycle_cnt = 0;
    // Position in the PWM period counted from reset release
    logic [DUTY_W-1:0]    phase = '0;
    // LED value the host last wrote, masked to the port width
    logic [31:0]          led_expected;

    audio_top #(
        .SAMPLE_COUNT_MAX(4),
        .PULSE_COUNT_MAX (3)
    ) u_audio_top (.*);

    always #4 cpu_clk_g = ~cpu_clk_g;

    always @(posedge cpu_clk_g) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst_n) begin
            phase <= phase + 1'b1;
        end
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s actual 0x%0h expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // Response sampled in the middle of the access phase
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge cpu_clk_g);
        #1;
        penable = 1'b1;
        #2;
        err = pslverr;
        @(posedge cpu_clk_g);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge cpu_clk_g);
        #1;
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        @(posedge cpu_clk_g);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected,
                               input string name);
        logic [31:0] rdata;
        logic        err;
        apb_read(addr, rdata, err);
        check({name, " pslverr"}, 32'(err), 32'd0);
        check(name, rdata, expected);
    endtask

    task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                                input logic exp_err, input string name);
        logic err;
        apb_write(addr, data, err);
        check({name, " pslverr"}, 32'(err), 32'(exp_err));
    endtask

    task automatic wait_req_clear();
        logic [31:0] rdata;
        logic        err;
        rdata = 32'h4;
        while (rdata[2]) begin
            apb_read(REG_STATUS, rdata, err);
            check("status poll pslverr", 32'(err), 32'd0);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge cpu_clk_g);
            #1;
        end
    endtask

    // Returns at the first cycle of the next PWM period
    task automatic align_to_period();
        while (phase != 12'd1) begin
            @(posedge cpu_clk_g);
            #1;
        end
    endtask

    task automatic measure_pwm(output int high);
        high = 0;
        repeat (PERIOD) begin
            if (pwm) begin
                high++;
            end
            @(posedge cpu_clk_g);
            #1;
        end
    endtask

    task automatic press_button(input int idx);
        buttons[idx] = 1'b1;
        repeat (40) begin
            @(posedge cpu_clk_g);
            #1;
        end
        buttons[idx] = 1'b0;
        repeat (12) begin
            @(posedge cpu_clk_g);
            #1;
        end
    endtask

    task automatic reset_and_leds();
        logic [31:0] led_val;
        int          high;
        measure_pwm(high);
        check("pwm high count after reset", high, 32'd0);
        read_expect(REG_STATUS, 32'h2, "status after reset");
        read_expect(REG_CTRL, 32'h0, "ctrl after reset");
        read_expect(REG_BUTTONS, 32'h0, "buttons after reset");
        read_expect(REG_LEDS, 32'h0, "leds after reset");
        led_val = $urandom;
        led_expected = led_val & 32'h3F;
        write_expect(REG_LEDS, led_val, 1'b0, "leds write");
        check("leds port", 32'(leds), led_expected);
        read_expect(REG_LEDS, led_expected, "leds readback");
    endtask

    task automatic direct_duty_sweep();
        logic [31:0] duties [5];
        int          high;
        duties[0] = $urandom & 32'hFFF;
        duties[1] = $urandom & 32'hFFF;
        duties[2] = $urandom & 32'hFFF;
        duties[3] = 32'd0;
        duties[4] = 32'd4095;
        foreach (duties[i]) begin
            write_expect(REG_DUTY, duties[i], 1'b0, "duty write");
            wait_req_clear();
            measure_pwm(high);
            check("pwm high count direct", high, duties[i]);
            read_expect(REG_DUTY, duties[i], "duty readback");
        end
    endtask

    task automatic fifo_playback();
        logic [31:0] samples [4];
        int          high;
        foreach (samples[i]) begin
            samples[i] = $urandom & 32'hFFF;
        end
        // Setup fits well inside one period, so sample 0 loads at the next boundary
        align_to_period();
        write_expect(REG_CTRL, 32'(SRC_FIFO), 1'b0, "ctrl write");
        foreach (samples[i]) begin
            write_expect(REG_FIFO, samples[i], 1'b0, "fifo push");
        end
        read_expect(REG_STATUS, 32'h1, "status full");
        write_expect(REG_FIFO, 32'h0AB, 1'b1, "push into full fifo");
        align_to_period();
        foreach (samples[i]) begin
            measure_pwm(high);
            check("pwm high count fifo", high, samples[i]);
        end
        read_expect(REG_STATUS, 32'h2, "status drained");
        measure_pwm(high);
        check("pwm held duty", high, samples[3]);
    endtask

    task automatic button_presses();
        press_button(0);
        read_expect(REG_BUTTONS, 32'h1, "sticky after press 0");
        press_button(2);
        read_expect(REG_BUTTONS, 32'h5, "sticky after press 2");
        // Pressed again while still set
        press_button(0);
        read_expect(REG_BUTTONS, 32'h5, "sticky after second press 0");
        write_expect(REG_BUTTONS, 32'h1, 1'b0, "clear bit 0");
        read_expect(REG_BUTTONS, 32'h4, "sticky after clear 0");
        // A held button fires once, so a bit cleared during the hold stays clear
        buttons[1] = 1'b1;
        wait_cycles(20);
        read_expect(REG_BUTTONS, 32'h6, "sticky after press 1");
        write_expect(REG_BUTTONS, 32'h2, 1'b0, "clear bit 1 while held");
        wait_cycles(40);
        read_expect(REG_BUTTONS, 32'h4, "sticky while button 1 held");
        buttons[1] = 1'b0;
        wait_cycles(12);
        write_expect(REG_BUTTONS, 32'h4, 1'b0, "clear bit 2");
        read_expect(REG_BUTTONS, 32'h0, "sticky after clear 2");
    endtask

    task automatic bus_error_responses();
        logic [31:0] rdata;
        logic        err;
        apb_read(8'h18, rdata, err);
        check("unmapped read pslverr", 32'(err), 32'd1);
        write_expect(8'h1C, 32'h0, 1'b1, "unmapped write");
        write_expect(REG_STATUS, 32'h0, 1'b1, "status write");
        apb_read(REG_FIFO, rdata, err);
        check("fifo read pslverr", 32'(err), 32'd1);
        read_expect(REG_CTRL, 32'(SRC_FIFO), "ctrl after errors");
        read_expect(REG_DUTY, 32'hFFF, "duty after errors");
        read_expect(REG_STATUS, 32'h2, "status after errors");
        read_expect(REG_BUTTONS, 32'h0, "buttons after errors");
        read_expect(REG_LEDS, led_expected, "leds after errors");
        check("leds port after errors", 32'(leds), led_expected);
    endtask

    initial begin
        cpu_clk_g = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        buttons   = '0;
        void'($urandom(32'h7cc7));
        repeat (2) @(posedge cpu_clk_g);
        #1;
        rst_n = 1'b1;
        reset_and_leds();
        direct_duty_sweep();
        fifo_playback();
        button_presses();
        bus_error_responses();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: sources.f
source/audio_pkg.sv
source/button_parser.sv
source/audio_regs.sv
source/sample_fifo.sv
source/pwm_dac.sv
source/audio_top.sv
test/tb_audio_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the audio subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_audio_top -f sources.f -o sim_audio
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_audio
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0
